// File: bench/rvm_model.svh
`ifndef RVM_MODEL_SVH
`define RVM_MODEL_SVH

// Product halves taken from a 64-bit product of the extended operands
function automatic logic [31:0] mul_reference(
    input rvm_op_e     op,
    input logic [31:0] a,
    input logic [31:0] b
);
    rvm_product_u prod;
    logic [63:0]  a_wide;
    logic [63:0]  b_wide;
    a_wide = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'h0, a};
    b_wide = (op == MULH) ? {{32{b[31]}}, b} : {32'h0, b};
    // Low 64 bits of the product are exact modulo 2^64
    prod.full = a_wide * b_wide;
    if (op == MUL) begin
        return prod.half.lo;
    end else begin
        return prod.half.hi;
    end
endfunction

// Divide results as the RISC-V spec defines them
function automatic logic [31:0] div_reference(
    input rvm_op_e     op,
    input logic [31:0] a,
    input logic [31:0] b
);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] wide;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (b == '0) begin
        return (op == DIV || op == DIVU) ? 32'hffff_ffff : a;
    end
    // 64-bit signed math avoids the -2^31 / -1 overflow
    case (op)
        DIV:     wide = sa / sb;
        REM:     wide = sa % sb;
        DIVU:    wide = {32'h0, a / b};
        default: wide = {32'h0, a % b};
    endcase
    return wide[31:0];
endfunction

function automatic logic [31:0] expected_result(
    input rvm_op_e     op,
    input logic [31:0] a,
    input logic [31:0] b
);
    return op[2] ? div_reference(op, a, b) : mul_reference(op, a, b);
endfunction

`endif

// File: bench/rvm_unit_tb.sv
`timescale 1ns/1ps

module rvm_unit_tb
    import rvm_op_pkg::*;
    import rvm_data_pkg::*;
();

`include "rvm_settings.svh"
`include "rvm_model.svh"

    localparam int CLK_HALF    = 20;
    localparam int CLK_PERIOD  = 2 * CLK_HALF;
    localparam int STIM_CYCLES = 2000;

    logic        clk;
    logic        arst_n;
    logic        valid;
    rvm_op_e     op;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [4:0]  rd;
    logic        out_valid;
    logic [31:0] out_result;
    logic [4:0]  out_rd;

    integer seed = 32'h5eac_45e5;
    int     cyc = 0;
    int     stim_count = 0;
    int     value_errors = 0;
    int     strobe_errors = 0;

    // Expected results with the oldest request at the head
    int          exp_tag  [$];
    logic [31:0] exp_res  [$];
    logic [4:0]  exp_rd   [$];
    string       exp_name [$];

    logic [31:0] corner [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    rvm_unit uut (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .valid_i  (valid),
        .op_i     (op),
        .src_a_i  (src_a),
        .src_b_i  (src_b),
        .rd_i     (rd),
        .valid_o  (out_valid),
        .result_o (out_result),
        .rd_o     (out_rd)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Zero, -1 and the most negative value show up often
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return 32'h0;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            default: return $random(seed);
        endcase
    endfunction

    // Result due RVM_LATENCY cycles after the issue cycle
    task automatic drive_request(
        input logic        vld,
        input rvm_op_e     req_op,
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [4:0]  req_rd
    );
        @(posedge clk);
        #1;
        valid = vld;
        op    = req_op;
        src_a = a;
        src_b = b;
        rd    = req_rd;
        if (vld) begin
            exp_tag.push_back(cyc + `RVM_LATENCY);
            exp_res.push_back(expected_result(req_op, a, b));
            exp_rd.push_back(req_rd);
            exp_name.push_back($sformatf("%s %h,%h", req_op.name(), a, b));
        end
        stim_count++;
    endtask

    // Compare on the falling edge where outputs are stable
    always @(negedge clk) begin
        if (out_valid) begin
            if (exp_tag.size() == 0 || exp_tag[0] != cyc) begin
                $display("valid_o rose at cycle %0d with no request due", cyc);
                strobe_errors++;
            end else begin
                if (out_result !== exp_res[0]) begin
                    $display("Fail %s result: expected %h actual %h",
                             exp_name[0], exp_res[0], out_result);
                    value_errors++;
                end
                if (out_rd !== exp_rd[0]) begin
                    $display("Fail %s rd: expected %0d actual %0d",
                             exp_name[0], exp_rd[0], out_rd);
                    value_errors++;
                end
                void'(exp_tag.pop_front());
                void'(exp_res.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_name.pop_front());
            end
        end
        if (exp_tag.size() != 0 && exp_tag[0] <= cyc) begin
            $display("No valid_o for %s at cycle %0d", exp_name[0], exp_tag[0]);
            strobe_errors++;
            void'(exp_tag.pop_front());
            void'(exp_res.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_name.pop_front());
        end
    end

    initial begin
        #((STIM_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the run did not complete within %0d cycles", STIM_CYCLES + 20);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] r;
        valid  = 1'b0;
        op     = MUL;
        src_a  = '0;
        src_b  = '0;
        rd     = '0;
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Every op over every corner pair back to back
        for (int o = 0; o < 8; o++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    r = $random(seed);
                    drive_request(1'b1, rvm_op_e'(o[2:0]), corner[i], corner[j], r[4:0]);
                end
            end
        end

        // Mixed traffic with random idle gaps
        while (stim_count < STIM_CYCLES) begin
            r = $random(seed);
            drive_request(r[1:0] != 2'b00, rvm_op_e'(r[4:2]), pick_operand(),
                          pick_operand(), r[9:5]);
        end
        drive_request(1'b0, MUL, '0, '0, '0);

        while (exp_tag.size() != 0) begin
            @(posedge clk);
        end
        repeat (`RVM_LATENCY + 1) @(posedge clk);

        $display("Errors: %0d wrong values, %0d strobe errors", value_errors, strobe_errors);
        if (value_errors + strobe_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : rvm_unit_tb

// File: rtl/rvm_data_pkg.sv
package rvm_data_pkg;

    // Upper and lower words of a product
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } rvm_halves_t;

    // Double width product
    // full is written by the adder tree, half is read by the result select
    typedef union packed {
        logic [63:0] full;
        rvm_halves_t half;
    } rvm_product_u;

endpackage : rvm_data_pkg

// File: rtl/rvm_div_unit.sv
`timescale 1ns/1ps

`include "rvm_settings.svh"

module rvm_div_unit
    import rvm_op_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 valid_i,
    input  rvm_op_e              op_i,
    input  logic [`RVM_XLEN-1:0] src_a_i,
    input  logic [`RVM_XLEN-1:0] src_b_i,
    output logic                 valid_o,
    output logic [`RVM_XLEN-1:0] result_o
);

    localparam int XLEN   = `RVM_XLEN;
    localparam int BITS   = `RVM_DIV_BITS_PER_STAGE;
    localparam int STAGES = XLEN / BITS;

    // Restoring division, BITS quotient bits per call
    // quo starts as the dividend and shifts quotient bits in from the bottom
    function automatic logic [2*XLEN-1:0] div_iter(
        input logic [XLEN-1:0] rem,
        input logic [XLEN-1:0] quo,
        input logic [XLEN-1:0] dsr
    );
        logic [XLEN:0]   trial;
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] q;
        r = rem;
        q = quo;
        for (int i = 0; i < BITS; i++) begin
            trial = {r, q[XLEN-1]};
            q     = {q[XLEN-2:0], 1'b0};
            if (trial >= {1'b0, dsr}) begin
                trial = trial - {1'b0, dsr};
                q[0]  = 1'b1;
            end
            r = trial[XLEN-1:0];
        end
        return {r, q};
    endfunction

    logic            signed_op;
    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;

    // One entry per iteration stage
    logic            it_vld      [STAGES];
    logic [XLEN-1:0] it_rem      [STAGES];
    logic [XLEN-1:0] it_quo      [STAGES];
    logic [XLEN-1:0] it_dsr      [STAGES];
    logic [XLEN-1:0] it_dividend [STAGES];
    logic            it_q_neg    [STAGES];
    logic            it_r_neg    [STAGES];
    logic            it_dz       [STAGES];
    logic            it_rem_sel  [STAGES];

    logic [XLEN-1:0] q_fin;
    logic [XLEN-1:0] r_fin;

    // DIV and REM have funct3 bit 0 clear
    always_comb begin
        signed_op = !op_i[0];
        a_neg     = signed_op && src_a_i[XLEN-1];
        b_neg     = signed_op && src_b_i[XLEN-1];
        a_mag     = a_neg ? -src_a_i : src_a_i;
        b_mag     = b_neg ? -src_b_i : src_b_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < STAGES; k++) begin
                it_vld[k] <= 1'b0;
            end
            valid_o <= 1'b0;
        end else begin
            it_vld[0] <= valid_i && op_i[2];
            for (int k = 1; k < STAGES; k++) begin
                it_vld[k] <= it_vld[k-1];
            end
            valid_o <= it_vld[STAGES-1];
        end
    end

    always_ff @(posedge clk_i) begin
        {it_rem[0], it_quo[0]} <= div_iter('0, a_mag, b_mag);
        it_dsr[0]              <= b_mag;
        it_dividend[0]         <= src_a_i;
        it_q_neg[0]            <= a_neg ^ b_neg;
        it_r_neg[0]            <= a_neg;
        it_dz[0]               <= (src_b_i == '0);
        it_rem_sel[0]          <= op_i[1];
        for (int k = 1; k < STAGES; k++) begin
            {it_rem[k], it_quo[k]} <= div_iter(it_rem[k-1], it_quo[k-1], it_dsr[k-1]);
            it_dsr[k]              <= it_dsr[k-1];
            it_dividend[k]         <= it_dividend[k-1];
            it_q_neg[k]            <= it_q_neg[k-1];
            it_r_neg[k]            <= it_r_neg[k-1];
            it_dz[k]               <= it_dz[k-1];
            it_rem_sel[k]          <= it_rem_sel[k-1];
        end
    end

    // Signed overflow needs no special case, 2^31 magnitude wraps to 0x8000_0000
    always_comb begin
        q_fin = it_q_neg[STAGES-1] ? -it_quo[STAGES-1] : it_quo[STAGES-1];
        r_fin = it_r_neg[STAGES-1] ? -it_rem[STAGES-1] : it_rem[STAGES-1];
        if (it_dz[STAGES-1]) begin
            q_fin = '1;
            r_fin = it_dividend[STAGES-1];
        end
    end

    always_ff @(posedge clk_i) begin
        result_o <= it_rem_sel[STAGES-1] ? r_fin : q_fin;
    end

    // Checks the whole iteration chain across all stages
    a_rem_bound: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (it_vld[STAGES-1] && !it_dz[STAGES-1]) |-> (it_rem[STAGES-1] < it_dsr[STAGES-1])
    );

endmodule : rvm_div_unit

// File: rtl/rvm_mul_unit.sv
`timescale 1ns/1ps

`include "rvm_settings.svh"

module rvm_mul_unit
    import rvm_op_pkg::*;
    import rvm_data_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 valid_i,
    input  rvm_op_e              op_i,
    input  logic [`RVM_XLEN-1:0] src_a_i,
    input  logic [`RVM_XLEN-1:0] src_b_i,
    output logic                 valid_o,
    output logic [`RVM_XLEN-1:0] result_o
);

    localparam int XLEN = `RVM_XLEN;
    localparam int HALF = XLEN / 2;
    localparam int PW   = 2 * XLEN;
    localparam int XW   = 2 * HALF + 2;

    logic            a_signed;
    logic            b_signed;
    logic [XLEN:0]   a_ext;
    logic [XLEN:0]   b_ext;

    logic            s1_vld;
    rvm_op_e         s1_op;
    logic [XLEN:0]   s1_a;
    logic [XLEN:0]   s1_b;

    logic [2*HALF-1:0]    pp_ll;
    logic signed [XW-1:0] pp_lh;
    logic signed [XW-1:0] pp_hl;
    logic signed [XW-1:0] pp_hh;

    logic                 s2_vld;
    rvm_op_e              s2_op;
    logic [2*HALF-1:0]    s2_ll;
    logic signed [XW-1:0] s2_lh;
    logic signed [XW-1:0] s2_hl;
    logic signed [XW-1:0] s2_hh;

    rvm_product_u    prod_d;
    logic            s3_vld;
    rvm_op_e         s3_op;
    rvm_product_u    s3_prod;

    logic            s4_vld;
    logic [XLEN-1:0] s4_res;

    // MULHSU takes a signed, b unsigned
    always_comb begin
        a_signed = (op_i == MULH) || (op_i == MULHSU);
        b_signed = (op_i == MULH);
        a_ext    = {a_signed & src_a_i[XLEN-1], src_a_i};
        b_ext    = {b_signed & src_b_i[XLEN-1], src_b_i};
    end

    // Low parts unsigned, upper 17-bit parts signed
    always_comb begin
        pp_ll = s1_a[HALF-1:0] * s1_b[HALF-1:0];
        pp_lh = $signed({1'b0, s1_a[HALF-1:0]}) * $signed(s1_b[XLEN:HALF]);
        pp_hl = $signed(s1_a[XLEN:HALF]) * $signed({1'b0, s1_b[HALF-1:0]});
        pp_hh = $signed(s1_a[XLEN:HALF]) * $signed(s1_b[XLEN:HALF]);
    end

    // Bits above 64 are dropped, the low 64 are exact
    always_comb begin
        prod_d.full = {{(PW-2*HALF){1'b0}}, s2_ll}
                    + {{(PW-XW-HALF){s2_lh[XW-1]}}, s2_lh, {HALF{1'b0}}}
                    + {{(PW-XW-HALF){s2_hl[XW-1]}}, s2_hl, {HALF{1'b0}}}
                    + {s2_hh[PW-2*HALF-1:0], {(2*HALF){1'b0}}};
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_vld  <= 1'b0;
            s2_vld  <= 1'b0;
            s3_vld  <= 1'b0;
            s4_vld  <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            s1_vld  <= valid_i && !op_i[2];
            s2_vld  <= s1_vld;
            s3_vld  <= s2_vld;
            s4_vld  <= s3_vld;
            valid_o <= s4_vld;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_op    <= op_i;
        s1_a     <= a_ext;
        s1_b     <= b_ext;
        s2_op    <= s1_op;
        s2_ll    <= pp_ll;
        s2_lh    <= pp_lh;
        s2_hl    <= pp_hl;
        s2_hh    <= pp_hh;
        s3_op    <= s2_op;
        s3_prod  <= prod_d;
        s4_res   <= (s3_op == MUL) ? s3_prod.half.lo : s3_prod.half.hi;
        result_o <= s4_res;
    end

    // Reset must flush every stage, not just the output
    a_reset_flush: assert property (@(posedge clk_i) !arst_n_i |=> !valid_o);

endmodule : rvm_mul_unit

// File: rtl/rvm_op_pkg.sv
package rvm_op_pkg;

    // Values follow the RV32M funct3 field
    // Bit 2 set marks the divide family
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } rvm_op_e;

endpackage : rvm_op_pkg

// File: rtl/rvm_settings.svh
`ifndef RVM_SETTINGS_SVH
`define RVM_SETTINGS_SVH

// Operand and result width
`define RVM_XLEN 32

// Destination register address width
`define RVM_REG_AW 5

// Quotient bits resolved in each divider stage
`define RVM_DIV_BITS_PER_STAGE 8

// Request to result latency in cycles
`define RVM_LATENCY 5

`endif

// File: rtl/rvm_unit.sv
`timescale 1ns/1ps

module rvm_unit
    import rvm_op_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        valid_i,
    input  rvm_op_e     op_i,
    input  logic [31:0] src_a_i,
    input  logic [31:0] src_b_i,
    input  logic [4:0]  rd_i,
    output logic        valid_o,
    output logic [31:0] result_o,
    output logic [4:0]  rd_o
);

    logic        mul_valid;
    logic [31:0] mul_result;
    logic        div_valid;
    logic [31:0] div_result;

    // Both units see every request and pick their own family
    rvm_mul_unit u_mul (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .src_a_i  (src_a_i),
        .src_b_i  (src_b_i),
        .valid_o  (mul_valid),
        .result_o (mul_result)
    );

    rvm_div_unit u_div (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .src_a_i  (src_a_i),
        .src_b_i  (src_b_i),
        .valid_o  (div_valid),
        .result_o (div_result)
    );

    rvm_writeback u_wb (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .rd_i         (rd_i),
        .mul_valid_i  (mul_valid),
        .mul_result_i (mul_result),
        .div_valid_i  (div_valid),
        .div_result_i (div_result),
        .valid_o      (valid_o),
        .result_o     (result_o),
        .rd_o         (rd_o)
    );

endmodule : rvm_unit

// File: rtl/rvm_writeback.sv
`timescale 1ns/1ps

`include "rvm_settings.svh"

module rvm_writeback (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   valid_i,
    input  logic [`RVM_REG_AW-1:0] rd_i,
    input  logic                   mul_valid_i,
    input  logic [`RVM_XLEN-1:0]   mul_result_i,
    input  logic                   div_valid_i,
    input  logic [`RVM_XLEN-1:0]   div_result_i,
    output logic                   valid_o,
    output logic [`RVM_XLEN-1:0]   result_o,
    output logic [`RVM_REG_AW-1:0] rd_o
);

    localparam int LAT = `RVM_LATENCY;

    logic                   req_q [LAT];
    logic [`RVM_REG_AW-1:0] rd_q  [LAT];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < LAT; k++) begin
                req_q[k] <= 1'b0;
            end
        end else begin
            req_q[0] <= valid_i;
            for (int k = 1; k < LAT; k++) begin
                req_q[k] <= req_q[k-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rd_q[0] <= rd_i;
        for (int k = 1; k < LAT; k++) begin
            rd_q[k] <= rd_q[k-1];
        end
    end

    assign valid_o  = mul_valid_i | div_valid_i;
    assign result_o = div_valid_i ? div_result_i : mul_result_i;
    assign rd_o     = rd_q[LAT-1];

    // At most one unit finishes per cycle
    a_one_hot: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(mul_valid_i && div_valid_i)
    );

    // Every request yields exactly one result, LAT cycles later
    a_no_lost: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) (mul_valid_i | div_valid_i) == req_q[LAT-1]
    );

endmodule : rvm_writeback

// File: run.sh
#!/bin/sh
# Build and run the RV32M unit testbench with Verilator

verilator --binary --timing --assert --top-module rvm_unit_tb \
    -f rvm_unit.f -o rvm_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/rvm_sim)
echo "$out"

echo "$out" | grep -q "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: rvm_unit.f
+incdir+rtl
+incdir+bench
rtl/rvm_op_pkg.sv
rtl/rvm_data_pkg.sv
rtl/rvm_mul_unit.sv
rtl/rvm_div_unit.sv
rtl/rvm_writeback.sv
rtl/rvm_unit.sv
bench/rvm_unit_tb.sv
